//--- source/core_rd_pkg.sv
package core_rd_pkg;

    //------------------------------
    // widths
    //------------------------------
    localparam int beat_w = 256;
    localparam int dim_w  = 11;
    localparam int edge_w = 5;
    localparam int xfer_w = 13;

    typedef logic [beat_w-1:0] beat_t;
    typedef logic [dim_w-1:0]  dim_t;
    typedef logic [edge_w-1:0] edge_t;
    typedef logic [xfer_w-1:0] xfer_len_t;

    //------------------------------
    // frame geometry
    //------------------------------
    // left pad may be as wide as a feature row
    typedef struct packed {
        edge_t up_len;
        dim_t  left_len;
        edge_t right_len;
        edge_t bottom_len;
        dim_t  row_num;
        dim_t  col_num;
    } pad_geom_t;

    //------------------------------
    // state encodings
    //------------------------------
    typedef enum logic [2:0] {
        region_idle,
        region_up,
        region_left,
        region_feature,
        region_right,
        region_bottom
    } pad_region_e;

    typedef enum logic [1:0] {
        route_idle,
        route_pad,
        route_direct
    } route_state_e;

endpackage

//--- source/pad_stream_if.sv
`timescale 1ns/1ps

interface pad_stream_if (
    input logic clk
);

    // padded beats from the walker
    core_rd_pkg::beat_t pad_data;
    logic               pad_valid;
    logic               pad_last;

    // source back-pressure, high only in the feature region
    logic               feat_ready;

    modport walker (
        input  clk,
        output pad_data,
        output pad_valid,
        output pad_last,
        output feat_ready
    );

    modport router (
        input  clk,
        input  pad_data,
        input  pad_valid,
        input  pad_last,
        input  feat_ready
    );

endinterface

//--- source/pad_frame_walker.sv
`timescale 1ns/1ps

module pad_frame_walker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_rd_pkg::pad_geom_t geom,
    input  logic                   walk_start,
    input  core_rd_pkg::beat_t     noc_in_data,
    input  logic                   noc_in_valid,
    pad_stream_if.walker           stream
);

    core_rd_pkg::pad_region_e region, region_ns;
    core_rd_pkg::dim_t        row_cnt, row_cnt_ns;
    core_rd_pkg::dim_t        col_cnt, col_cnt_ns;

    core_rd_pkg::dim_t        total_col_last;
    core_rd_pkg::dim_t        up_row_last;
    core_rd_pkg::dim_t        bottom_row_last;
    core_rd_pkg::dim_t        left_col_last;
    core_rd_pkg::dim_t        right_col_last;
    core_rd_pkg::dim_t        feat_col_last;
    core_rd_pkg::dim_t        feat_row_last;

    core_rd_pkg::pad_region_e row_entry;
    core_rd_pkg::pad_region_e first_region;
    core_rd_pkg::pad_region_e row_exit_region;
    core_rd_pkg::dim_t        row_exit_cnt;
    logic                     row_exit_last;

    //------------------------------
    // geometry derived limits
    //------------------------------
    assign total_col_last  = core_rd_pkg::dim_t'(geom.right_len) + geom.left_len
                           + geom.col_num - 1'b1;
    assign up_row_last     = core_rd_pkg::dim_t'(geom.up_len) - 1'b1;
    assign bottom_row_last = core_rd_pkg::dim_t'(geom.bottom_len) - 1'b1;
    assign left_col_last   = geom.left_len - 1'b1;
    assign right_col_last  = core_rd_pkg::dim_t'(geom.right_len) - 1'b1;
    assign feat_col_last   = geom.col_num - 1'b1;
    assign feat_row_last   = geom.row_num - 1'b1;

    // empty regions are skipped
    assign row_entry    = (geom.left_len != '0) ? core_rd_pkg::region_left
                                                : core_rd_pkg::region_feature;
    assign first_region = (geom.up_len != '0) ? core_rd_pkg::region_up : row_entry;

    // where a feature row goes once its last beat is out
    always_comb begin
        row_exit_last = 1'b0;
        if (row_cnt == feat_row_last) begin
            row_exit_cnt = '0;
            if (geom.bottom_len != '0) begin
                row_exit_region = core_rd_pkg::region_bottom;
            end
            else begin
                row_exit_region = core_rd_pkg::region_idle;
                row_exit_last   = 1'b1;
            end
        end
        else begin
            row_exit_cnt    = row_cnt + 1'b1;
            row_exit_region = row_entry;
        end
    end

    //------------------------------
    // region FSM
    //------------------------------
    always_comb begin
        region_ns         = region;
        row_cnt_ns        = row_cnt;
        col_cnt_ns        = col_cnt;
        stream.pad_data   = '0;
        stream.pad_valid  = 1'b0;
        stream.pad_last   = 1'b0;
        stream.feat_ready = 1'b0;

        case (region)
            core_rd_pkg::region_idle: begin
                if (walk_start) begin
                    region_ns  = first_region;
                    row_cnt_ns = '0;
                    col_cnt_ns = '0;
                end
            end
            core_rd_pkg::region_up: begin
                stream.pad_valid = 1'b1;
                if (col_cnt == total_col_last) begin
                    col_cnt_ns = '0;
                    if (row_cnt == up_row_last) begin
                        row_cnt_ns = '0;
                        region_ns  = row_entry;
                    end
                    else begin
                        row_cnt_ns = row_cnt + 1'b1;
                    end
                end
                else begin
                    col_cnt_ns = col_cnt + 1'b1;
                end
            end
            core_rd_pkg::region_left: begin
                stream.pad_valid = 1'b1;
                if (col_cnt == left_col_last) begin
                    col_cnt_ns = '0;
                    region_ns  = core_rd_pkg::region_feature;
                end
                else begin
                    col_cnt_ns = col_cnt + 1'b1;
                end
            end
            core_rd_pkg::region_feature: begin
                stream.pad_data   = noc_in_data;
                stream.pad_valid  = noc_in_valid;
                stream.feat_ready = 1'b1;
                if (noc_in_valid) begin
                    if (col_cnt == feat_col_last) begin
                        col_cnt_ns = '0;
                        if (geom.right_len != '0) begin
                            region_ns = core_rd_pkg::region_right;
                        end
                        else begin
                            region_ns       = row_exit_region;
                            row_cnt_ns      = row_exit_cnt;
                            stream.pad_last = row_exit_last;
                        end
                    end
                    else begin
                        col_cnt_ns = col_cnt + 1'b1;
                    end
                end
            end
            core_rd_pkg::region_right: begin
                stream.pad_valid = 1'b1;
                if (col_cnt == right_col_last) begin
                    col_cnt_ns      = '0;
                    region_ns       = row_exit_region;
                    row_cnt_ns      = row_exit_cnt;
                    stream.pad_last = row_exit_last;
                end
                else begin
                    col_cnt_ns = col_cnt + 1'b1;
                end
            end
            core_rd_pkg::region_bottom: begin
                stream.pad_valid = 1'b1;
                if (col_cnt == total_col_last) begin
                    col_cnt_ns = '0;
                    if (row_cnt == bottom_row_last) begin
                        row_cnt_ns      = '0;
                        region_ns       = core_rd_pkg::region_idle;
                        stream.pad_last = 1'b1;
                    end
                    else begin
                        row_cnt_ns = row_cnt + 1'b1;
                    end
                end
                else begin
                    col_cnt_ns = col_cnt + 1'b1;
                end
            end
            default: begin
                region_ns = core_rd_pkg::region_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            region  <= core_rd_pkg::region_idle;
            row_cnt <= '0;
            col_cnt <= '0;
        end
        else begin
            region  <= region_ns;
            row_cnt <= row_cnt_ns;
            col_cnt <= col_cnt_ns;
        end
    end

endmodule

//--- source/rd_route_ctrl.sv
`timescale 1ns/1ps

module rd_route_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      core_rd_start,
    input  logic                      pad_enable,
    input  core_rd_pkg::edge_t        pad_up_len,
    input  core_rd_pkg::dim_t         pad_left_len,
    input  core_rd_pkg::edge_t        pad_right_len,
    input  core_rd_pkg::edge_t        pad_bottom_len,
    input  core_rd_pkg::dim_t         pad_row_num,
    input  core_rd_pkg::dim_t         pad_col_num,
    input  core_rd_pkg::xfer_len_t    target_len,
    input  core_rd_pkg::beat_t        noc_in_data,
    input  logic                      noc_in_valid,
    output core_rd_pkg::pad_geom_t    geom,
    output logic                      walk_start,
    output logic                      noc_in_ready,
    output core_rd_pkg::beat_t        core_in_data,
    output logic                      core_in_valid,
    output logic                      core_in_last,
    output logic                      core_rd_finish,
    pad_stream_if.router              stream
);

    core_rd_pkg::route_state_e route_state, route_ns;
    core_rd_pkg::xfer_len_t    target_q;
    core_rd_pkg::xfer_len_t    direct_cnt, direct_cnt_ns;
    logic                      start_take;

    // starts outside idle are dropped
    assign start_take = (route_state == core_rd_pkg::route_idle) && core_rd_start;

    //------------------------------
    // route FSM and output mux
    //------------------------------
    always_comb begin
        route_ns       = route_state;
        direct_cnt_ns  = direct_cnt;
        core_in_data   = stream.pad_data;
        core_in_valid  = 1'b0;
        core_in_last   = 1'b0;
        core_rd_finish = 1'b0;
        noc_in_ready   = 1'b0;

        case (route_state)
            core_rd_pkg::route_idle: begin
                if (start_take) begin
                    route_ns = pad_enable ? core_rd_pkg::route_pad
                                          : core_rd_pkg::route_direct;
                end
            end
            core_rd_pkg::route_pad: begin
                core_in_valid  = stream.pad_valid;
                core_in_last   = stream.pad_last;
                core_rd_finish = stream.pad_last;
                noc_in_ready   = stream.feat_ready;
                if (stream.pad_last) begin
                    route_ns = core_rd_pkg::route_idle;
                end
            end
            core_rd_pkg::route_direct: begin
                core_in_data  = noc_in_data;
                core_in_valid = noc_in_valid;
                noc_in_ready  = 1'b1;
                if (noc_in_valid) begin
                    // target_len + 1 beats in total
                    if (direct_cnt == target_q) begin
                        direct_cnt_ns  = '0;
                        core_in_last   = 1'b1;
                        core_rd_finish = 1'b1;
                        route_ns       = core_rd_pkg::route_idle;
                    end
                    else begin
                        direct_cnt_ns = direct_cnt + 1'b1;
                    end
                end
            end
            default: begin
                route_ns = core_rd_pkg::route_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_state <= core_rd_pkg::route_idle;
            direct_cnt  <= '0;
            walk_start  <= 1'b0;
            target_q    <= '0;
            geom        <= '0;
        end
        else begin
            route_state <= route_ns;
            direct_cnt  <= direct_cnt_ns;
            // first cycle of route_pad
            walk_start  <= start_take && pad_enable;
            if (start_take) begin
                target_q        <= target_len;
                geom.up_len     <= pad_up_len;
                geom.left_len   <= pad_left_len;
                geom.right_len  <= pad_right_len;
                geom.bottom_len <= pad_bottom_len;
                geom.row_num    <= pad_row_num;
                geom.col_num    <= pad_col_num;
            end
        end
    end

endmodule

//--- source/core_rd_pad_top.sv
`timescale 1ns/1ps

module core_rd_pad_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            core_rd_start,
    input  logic                            pad_enable,
    input  logic [core_rd_pkg::edge_w-1:0]  pad_up_len,
    input  logic [core_rd_pkg::dim_w-1:0]   pad_left_len,
    input  logic [core_rd_pkg::edge_w-1:0]  pad_right_len,
    input  logic [core_rd_pkg::edge_w-1:0]  pad_bottom_len,
    input  logic [core_rd_pkg::dim_w-1:0]   pad_row_num,
    input  logic [core_rd_pkg::dim_w-1:0]   pad_col_num,
    input  logic [core_rd_pkg::xfer_w-1:0]  target_len,
    input  logic [core_rd_pkg::beat_w-1:0]  noc_in_data,
    input  logic                            noc_in_valid,
    input  logic                            noc_in_last,
    output logic                            noc_in_ready,
    output logic [core_rd_pkg::beat_w-1:0]  core_in_data,
    output logic                            core_in_valid,
    output logic                            core_in_last,
    output logic                            core_rd_finish
);

    // noc_in_last kept on the boundary, frame end comes from the counters

    core_rd_pkg::pad_geom_t geom;
    logic                   walk_start;

    pad_stream_if u_stream (
        .clk (clk)
    );

    rd_route_ctrl u_route (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_rd_start  (core_rd_start),
        .pad_enable     (pad_enable),
        .pad_up_len     (pad_up_len),
        .pad_left_len   (pad_left_len),
        .pad_right_len  (pad_right_len),
        .pad_bottom_len (pad_bottom_len),
        .pad_row_num    (pad_row_num),
        .pad_col_num    (pad_col_num),
        .target_len     (target_len),
        .noc_in_data    (noc_in_data),
        .noc_in_valid   (noc_in_valid),
        .geom           (geom),
        .walk_start     (walk_start),
        .noc_in_ready   (noc_in_ready),
        .core_in_data   (core_in_data),
        .core_in_valid  (core_in_valid),
        .core_in_last   (core_in_last),
        .core_rd_finish (core_rd_finish),
        .stream         (u_stream.router)
    );

    pad_frame_walker u_walker (
        .clk          (clk),
        .rst_n        (rst_n),
        .geom         (geom),
        .walk_start   (walk_start),
        .noc_in_data  (noc_in_data),
        .noc_in_valid (noc_in_valid),
        .stream       (u_stream.walker)
    );

endmodule

//--- bench/tb_cases.svh
    // columns: pad_en up left right bottom rows cols target gap busy beats
    // beats is (up+rows+bottom)*(left+cols+right) when padding, target+1 when direct
    // gap 0 keeps the source valid every cycle, 1 and 2 leave random holes
    // busy pulses a second start halfway through the frame
    typedef struct packed {
        logic                   pad_en;
        core_rd_pkg::edge_t     up;
        core_rd_pkg::dim_t      left;
        core_rd_pkg::edge_t     right;
        core_rd_pkg::edge_t     bottom;
        core_rd_pkg::dim_t      rows;
        core_rd_pkg::dim_t      cols;
        core_rd_pkg::xfer_len_t target;
        logic [1:0]             gap;
        logic                   busy;
        logic [15:0]            beats;
    } tcase_t;

    localparam int n_cases = 9;

    tcase_t case_tab [n_cases];

    task automatic load_cases();
        case_tab[0] = '{1, 2, 1, 2, 1, 3, 4, 0, 0, 0, 42};
        case_tab[1] = '{1, 1, 2, 1, 2, 2, 3, 0, 2, 1, 30};
        case_tab[2] = '{1, 0, 1, 1, 1, 2, 2, 0, 1, 0, 12};
        case_tab[3] = '{1, 1, 0, 2, 0, 3, 2, 0, 1, 1, 16};
        case_tab[4] = '{1, 2, 3, 0, 2, 2, 1, 0, 2, 0, 24};
        // no padding at all
        case_tab[5] = '{1, 0, 0, 0, 0, 3, 3, 0, 2, 1, 9};
        case_tab[6] = '{0, 1, 1, 1, 1, 2, 2, 9, 1, 1, 10};
        case_tab[7] = '{0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1};
        case_tab[8] = '{1, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1};
    endtask

//--- bench/tb_core_rd_pad.sv
`timescale 1ns/1ps

module tb_core_rd_pad;

    logic                   clk, rst_n, core_rd_start, pad_enable;
    core_rd_pkg::edge_t     pad_up_len, pad_right_len, pad_bottom_len;
    core_rd_pkg::dim_t      pad_left_len, pad_row_num, pad_col_num;
    core_rd_pkg::xfer_len_t target_len;
    core_rd_pkg::beat_t     noc_in_data, core_in_data;
    logic                   noc_in_valid, noc_in_last, noc_in_ready;
    logic                   core_in_valid, core_in_last, core_rd_finish;

    logic [31:0] lfsr;
    int          err_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    `include "tb_cases.svh"

    core_rd_pad_top u_core_rd_pad_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //------------------------------
    // helpers
    //------------------------------
    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // marker byte keeps feature beats apart from pad zeros
    function automatic core_rd_pkg::beat_t src_beat(input int ci, input int k);
        return {8'ha5, 216'd0, 16'(ci), 16'(k)};
    endfunction

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic drive_config(input tcase_t tc);
        pad_enable     = tc.pad_en;
        pad_up_len     = tc.up;
        pad_left_len   = tc.left;
        pad_right_len  = tc.right;
        pad_bottom_len = tc.bottom;
        pad_row_num    = tc.rows;
        pad_col_num    = tc.cols;
        target_len     = tc.target;
    endtask

    task automatic check_idle();
        @(negedge clk);
        core_rd_start = 1'b0;
        noc_in_valid  = 1'b0;
        #1;
        check("core_in_valid", core_in_valid, 1'b0);
        check("core_in_last", core_in_last, 1'b0);
        check("core_rd_finish", core_rd_finish, 1'b0);
        check("noc_in_ready", noc_in_ready, 1'b0);
    endtask

    //------------------------------
    // one case: model, stimulus, checks
    //------------------------------
    task automatic run_case(input int ci);
        tcase_t             tc;
        core_rd_pkg::beat_t exp_data[$];
        bit                 exp_feat[$];
        bit                 is_feat;
        bit                 busy_done;
        bit                 done;
        int                 width;
        int                 n;
        int                 k;
        int                 got;
        int                 src_idx;
        int                 gap_v;

        tc    = case_tab[ci];
        k     = 0;
        width = int'(tc.left) + int'(tc.cols) + int'(tc.right);
        if (tc.pad_en) begin
            for (int r = 0; r < int'(tc.up) + int'(tc.rows) + int'(tc.bottom); r++) begin
                for (int c = 0; c < width; c++) begin
                    is_feat = (r >= int'(tc.up)) && (r < int'(tc.up) + int'(tc.rows))
                           && (c >= int'(tc.left)) && (c < int'(tc.left) + int'(tc.cols));
                    exp_data.push_back(is_feat ? src_beat(ci, k) : core_rd_pkg::beat_t'(0));
                    exp_feat.push_back(is_feat);
                    k = k + int'(is_feat);
                end
            end
        end
        else begin
            for (k = 0; k <= int'(tc.target); k++) begin
                exp_data.push_back(src_beat(ci, k));
                exp_feat.push_back(1'b1);
            end
        end
        n = exp_data.size();
        check("expected beat count", n, tc.beats);

        got       = 0;
        src_idx   = 0;
        busy_done = 1'b0;
        done      = 1'b0;
        for (int cyc = 0; !done; cyc++) begin
            @(negedge clk);
            drive_config(tc);
            core_rd_start = (cyc == 0);
            if (tc.busy && !busy_done && cyc > 0 && got == n / 2) begin
                // restart with other settings while the frame runs
                pad_enable    = ~tc.pad_en;
                pad_row_num   = 7;
                pad_up_len    = 3;
                target_len    = 5;
                core_rd_start = 1'b1;
                busy_done     = 1'b1;
            end
            draw_bits(2, gap_v);
            noc_in_valid = (src_idx < k) && (gap_v >= int'(tc.gap));
            noc_in_data  = src_beat(ci, src_idx);
            noc_in_last  = (src_idx == k - 1);
            #1;
            if (noc_in_ready) begin
                check("noc_in_ready", noc_in_ready, (got < n) && exp_feat[got]);
                src_idx = src_idx + int'(noc_in_valid);
            end
            if (core_in_valid) begin
                check("core_in_data", core_in_data, exp_data[got]);
                check("core_in_last", core_in_last, got == n - 1);
                check("core_rd_finish", core_rd_finish, got == n - 1);
                done = (got == n - 1);
                got++;
            end
            else begin
                check("core_in_last", core_in_last, 1'b0);
                check("core_rd_finish", core_rd_finish, 1'b0);
            end
        end
        check("source beats taken", src_idx, k);
        check_idle();
    endtask

    initial begin
        rst_n         = 1'b0;
        core_rd_start = 1'b0;
        noc_in_valid  = 1'b0;
        noc_in_last   = 1'b0;
        noc_in_data   = '0;
        drive_config(tcase_t'(0));
        lfsr          = 32'hbd37_c9d9;
        err_cnt       = 0;
        load_cases();
        for (int i = 0; i < n_cases; i++) begin
            cycle_limit = cycle_limit + 4 * int'(case_tab[i].beats) + 100;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end
        else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run length guard
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run was still busy after %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $fatal(1);
    end

endmodule

//--- list.f
+incdir+bench
source/core_rd_pkg.sv
source/pad_stream_if.sv
source/pad_frame_walker.sv
source/rd_route_ctrl.sv
source/core_rd_pad_top.sv
bench/tb_core_rd_pad.sv
